/* common/mem_access_settings.svh */
// Memory access stage settings
// Widths, instruction fields, op codes and control register indexes
`ifndef MEM_ACCESS_SETTINGS_SVH
`define MEM_ACCESS_SETTINGS_SVH

`define MA_LINE_W			512
`define MA_LANES			16
`define MA_ADDR_W			32
`define MA_WORD_W			32
`define MA_WB_REG_W			7
`define MA_CORE_ID_DEFAULT	30'h0

// Instruction fields
`define MA_FMT_HI			31
`define MA_FMT_LO			30
`define MA_FMT_MEM			2'b10
`define MA_LS_BIT			29		// 1 is load
`define MA_OP_HI			28
`define MA_OP_LO			25
`define MA_CR_HI			4
`define MA_CR_LO			0

`define MA_OP_B				4'd0
`define MA_OP_BX			4'd1
`define MA_OP_S				4'd2
`define MA_OP_SX			4'd3
`define MA_OP_L				4'd4
`define MA_OP_SYNC			4'd5
`define MA_OP_CTRL			4'd6
`define MA_OP_BLOCK			4'd7
`define MA_OP_BLOCK_M		4'd8
`define MA_OP_BLOCK_IM		4'd9
`define MA_OP_STRIDED		4'd10
`define MA_OP_STRIDED_M		4'd11
`define MA_OP_STRIDED_IM	4'd12
`define MA_OP_SCGATH		4'd13
`define MA_OP_SCGATH_M		4'd14
`define MA_OP_SCGATH_IM		4'd15

`define MA_CR_STRAND_ID		5'd0
`define MA_CR_SCRATCH		5'd7
`define MA_CR_STRAND_EN		5'd30
`define MA_CR_HALT			5'd31

`define MA_NOP				32'h0000_0000

`endif

/* common/mem_access_pkg.sv */
// Memory access stage types
// Shared vectors, access kinds and the bundles passed between blocks
`include "mem_access_settings.svh"

package mem_access_pkg;

	typedef logic [`MA_LINE_W-1:0]			line_t;
	typedef logic [`MA_WORD_W-1:0]			word_t;
	typedef logic [`MA_ADDR_W-1:0]			addr_t;
	typedef logic [`MA_LANES-1:0]			lane_mask_t;
	typedef logic [$clog2(`MA_LANES)-1:0]	lane_idx_t;
	typedef logic [`MA_LINE_W/8-1:0]		byte_en_t;
	typedef logic [1:0]						strand_t;
	typedef logic [4:0]						cr_idx_t;
	typedef logic [`MA_WB_REG_W-1:0]		wb_reg_t;

	// Masked variants share a kind
	typedef enum logic [2:0]
	{
		MEM_BYTE,
		MEM_HALF,
		MEM_WORD,
		MEM_SYNC,
		MEM_CTRL,
		MEM_BLOCK,
		MEM_STRIDED,
		MEM_SCGATH
	} mem_kind_e;

	typedef struct packed
	{
		logic		valid;
		word_t		instruction;
		strand_t	strand;
		addr_t		pc;
		line_t		store_value;
		line_t		result;
		lane_mask_t	mask;
		lane_idx_t	reg_lane;
		addr_t		base_addr;
		word_t		strided_offset;
		logic		has_writeback;
		wb_reg_t	writeback_reg;
		logic		writeback_is_vector;
	} ma_issue_t;

	typedef struct packed
	{
		logic		is_mem;
		logic		is_store;
		mem_kind_e	kind;
		cr_idx_t	cr_index;
		logic		lane_active;	// Mask bit of the register lane
	} ma_op_t;

	typedef struct packed
	{
		logic		access;
		logic		write;
		logic		sync;
		strand_t	strand;
		addr_t		address;
		lane_idx_t	cache_lane;
		byte_en_t	byte_en;
		line_t		data;
	} ma_dreq_t;

	typedef struct packed
	{
		logic		valid;
		word_t		instruction;
		strand_t	strand;
		addr_t		pc;
		lane_mask_t	mask;
		line_t		result;
		lane_idx_t	reg_lane;
		lane_idx_t	cache_lane;
		logic		has_writeback;
		wb_reg_t	writeback_reg;
		logic		writeback_is_vector;
		logic		was_access;
		word_t		strided_offset;
	} ma_wb_t;

endpackage

/* hdl/mem_op_decode.sv */
// Memory op decoder
// Maps format and op code bits to an access kind, store flag,
// control register index and the active bit of the register lane
`timescale 1ns/1ns
`include "mem_access_settings.svh"

module mem_op_decode
(
	input	mem_access_pkg::word_t		instruction_i,
	input	mem_access_pkg::lane_mask_t	mask_i,
	input	mem_access_pkg::lane_idx_t	reg_lane_i,
	output	mem_access_pkg::ma_op_t		op_o
);

	logic [3:0]					op_code;
	mem_access_pkg::lane_idx_t	lane_bit;

	assign op_code = instruction_i[`MA_OP_HI:`MA_OP_LO];
	assign lane_bit = ~reg_lane_i;		// Lane 0 is the top mask bit

	always_comb
	begin
		op_o.is_mem = instruction_i[`MA_FMT_HI:`MA_FMT_LO] == `MA_FMT_MEM;
		op_o.is_store = !instruction_i[`MA_LS_BIT];
		op_o.cr_index = instruction_i[`MA_CR_HI:`MA_CR_LO];
		op_o.lane_active = mask_i[lane_bit];

		case (op_code)
			`MA_OP_B, `MA_OP_BX:
				op_o.kind = mem_access_pkg::MEM_BYTE;
			`MA_OP_S, `MA_OP_SX:
				op_o.kind = mem_access_pkg::MEM_HALF;
			`MA_OP_L:
				op_o.kind = mem_access_pkg::MEM_WORD;
			`MA_OP_SYNC:
				op_o.kind = mem_access_pkg::MEM_SYNC;
			`MA_OP_CTRL:
				op_o.kind = mem_access_pkg::MEM_CTRL;
			`MA_OP_BLOCK, `MA_OP_BLOCK_M, `MA_OP_BLOCK_IM:
				op_o.kind = mem_access_pkg::MEM_BLOCK;
			`MA_OP_STRIDED, `MA_OP_STRIDED_M, `MA_OP_STRIDED_IM:
				op_o.kind = mem_access_pkg::MEM_STRIDED;
			default:	// Scatter/gather codes
				op_o.kind = mem_access_pkg::MEM_SCGATH;
		endcase
	end

endmodule

/* hdl/mem_address_gen.sv */
// Address generator
// Picks the scalar, strided or gather pointer, forms line address and
// cache lane, and decides access and write for the data cache
`timescale 1ns/1ns

module mem_address_gen
(
	input	mem_access_pkg::ma_op_t		op_i,
	input	mem_access_pkg::ma_issue_t	issue_i,
	input	logic						flush_i,
	output	mem_access_pkg::addr_t		address_o,
	output	mem_access_pkg::lane_idx_t	cache_lane_o,
	output	logic						access_o,
	output	logic						write_o,
	output	logic						unaligned_o
);

	mem_access_pkg::addr_t		strided_ptr;
	mem_access_pkg::addr_t		gather_ptr;
	mem_access_pkg::addr_t		ptr;
	mem_access_pkg::lane_idx_t	lane_rev;
	logic						go;

	assign lane_rev = ~issue_i.reg_lane;
	assign strided_ptr = issue_i.base_addr + issue_i.strided_offset;
	assign gather_ptr = issue_i.result[lane_rev * $bits(mem_access_pkg::word_t)
		+: $bits(mem_access_pkg::word_t)];

	always_comb
	begin
		case (op_i.kind)
			mem_access_pkg::MEM_STRIDED:
				ptr = strided_ptr;
			mem_access_pkg::MEM_SCGATH:
				ptr = gather_ptr;
			default:
				ptr = issue_i.result[31:0];
		endcase
	end

	assign address_o = {ptr[31:6], 6'd0};
	assign cache_lane_o = ptr[5:2];

	assign go = issue_i.valid && !flush_i && op_i.is_mem;

	// Block ignores the lane mask, the others need their lane enabled
	assign access_o = go && (op_i.kind == mem_access_pkg::MEM_BLOCK
		|| (op_i.kind != mem_access_pkg::MEM_CTRL && op_i.lane_active));
	assign write_o = go && op_i.is_store && op_i.kind != mem_access_pkg::MEM_CTRL;

	always_comb
	begin
		case (op_i.kind)
			mem_access_pkg::MEM_BYTE:
				unaligned_o = 1'b0;
			mem_access_pkg::MEM_HALF:
				unaligned_o = ptr[0];
			mem_access_pkg::MEM_BLOCK:
				unaligned_o = ptr[5:0] != 6'd0;		// Whole line
			default:
				unaligned_o = ptr[1:0] != 2'd0;
		endcase
	end

endmodule

/* store_align/store_align.sv */
// Store data alignment
// Places store values in the cache line with big-endian byte order
// and expands word and byte masks into the 64-bit byte write enable
`timescale 1ns/1ns
`include "mem_access_settings.svh"

module store_align
(
	input	mem_access_pkg::ma_op_t		op_i,
	input	mem_access_pkg::ma_issue_t	issue_i,
	input	mem_access_pkg::lane_idx_t	cache_lane_i,
	input	logic [1:0]					byte_offset_i,
	output	mem_access_pkg::byte_en_t	byte_en_o,
	output	mem_access_pkg::line_t		data_o
);

	mem_access_pkg::word_t		lane_val;
	mem_access_pkg::word_t		byte_word;
	mem_access_pkg::word_t		half_word;
	mem_access_pkg::lane_mask_t	lane_onehot;
	mem_access_pkg::lane_mask_t	word_mask;
	logic [3:0]					byte_mask;
	logic [15:0]				half_swap;

	function automatic mem_access_pkg::word_t swap32(input mem_access_pkg::word_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// Store value lane of the register, lane 0 on top
	always_comb
	begin
		lane_val = '0;
		for (int i = 0; i < `MA_LANES; i++)
		begin
			if (issue_i.reg_lane == i)
				lane_val = issue_i.store_value[(`MA_LANES-1-i)*`MA_WORD_W +: `MA_WORD_W];
		end
	end

	assign lane_onehot = {1'b1, {(`MA_LANES-1){1'b0}}} >> cache_lane_i;

	always_comb
	begin
		case (op_i.kind)
			mem_access_pkg::MEM_BLOCK:
				word_mask = issue_i.mask;
			mem_access_pkg::MEM_STRIDED, mem_access_pkg::MEM_SCGATH:
				word_mask = op_i.lane_active ? lane_onehot : '0;
			default:
				word_mask = lane_onehot;
		endcase

		case (op_i.kind)
			mem_access_pkg::MEM_BYTE:
				byte_mask = 4'b1000 >> byte_offset_i;
			mem_access_pkg::MEM_HALF:
				byte_mask = byte_offset_i[1] ? 4'b0011 : 4'b1100;
			default:
				byte_mask = 4'b1111;
		endcase
	end

	// Cross product, word 15 in the top nibble
	always_comb
	begin
		for (int w = 0; w < `MA_LANES; w++)
		begin
			for (int b = 0; b < 4; b++)
				byte_en_o[w*4 + b] = word_mask[w] & byte_mask[b];
		end
	end

	assign byte_word = {issue_i.store_value[7:0], 24'd0} >> {byte_offset_i, 3'b000};
	assign half_swap = {issue_i.store_value[7:0], issue_i.store_value[15:8]};
	assign half_word = byte_offset_i[1] ? {16'd0, half_swap} : {half_swap, 16'd0};

	always_comb
	begin
		case (op_i.kind)
			mem_access_pkg::MEM_BYTE:
				data_o = {`MA_LANES{byte_word}};
			mem_access_pkg::MEM_HALF:
				data_o = {`MA_LANES{half_word}};
			mem_access_pkg::MEM_WORD, mem_access_pkg::MEM_SYNC, mem_access_pkg::MEM_CTRL:
				data_o = {`MA_LANES{swap32(issue_i.store_value[31:0])}};
			mem_access_pkg::MEM_STRIDED, mem_access_pkg::MEM_SCGATH:
				data_o = {`MA_LANES{swap32(lane_val)}};
			default:	// Block swaps every word
			begin
				for (int i = 0; i < `MA_LANES; i++)
					data_o[i*`MA_WORD_W +: `MA_WORD_W] =
						swap32(issue_i.store_value[i*`MA_WORD_W +: `MA_WORD_W]);
			end
		endcase
	end

endmodule

/* hdl/control_regs.sv */
// Core control registers
// Strand ID, scratch and strand enable, read into the result word
// and written from store values
`timescale 1ns/1ns
`include "mem_access_settings.svh"

module control_regs
#(
	parameter logic [29:0]	core_id_p = `MA_CORE_ID_DEFAULT
)
(
	input	logic						clk,
	input	logic						arst_n_i,
	input	mem_access_pkg::ma_op_t		op_i,
	input	mem_access_pkg::ma_issue_t	issue_i,
	input	logic						flush_i,
	output	mem_access_pkg::line_t		result_nxt_o,
	output	logic [3:0]					strand_enable_o
);

	mem_access_pkg::word_t	scratch_q;
	logic					is_ctrl;
	logic					cr_write;

	assign is_ctrl = op_i.is_mem && op_i.kind == mem_access_pkg::MEM_CTRL;
	assign cr_write = issue_i.valid && !flush_i && is_ctrl && op_i.is_store;

	always_comb
	begin
		if (is_ctrl && !op_i.is_store)
		begin
			case (op_i.cr_index)
				`MA_CR_STRAND_ID:
					result_nxt_o = mem_access_pkg::line_t'({core_id_p, issue_i.strand});
				`MA_CR_SCRATCH:
					result_nxt_o = mem_access_pkg::line_t'(scratch_q);
				`MA_CR_STRAND_EN:
					result_nxt_o = mem_access_pkg::line_t'(strand_enable_o);
				default:
					result_nxt_o = '0;
			endcase
		end
		else
			result_nxt_o = issue_i.result;
	end

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			scratch_q <= '0;
			strand_enable_o <= 4'b0001;		// Only strand 0 runs
		end
		else if (cr_write)
		begin
			case (op_i.cr_index)
				`MA_CR_SCRATCH:
					scratch_q <= issue_i.store_value[31:0];
				`MA_CR_STRAND_EN:
					strand_enable_o <= issue_i.store_value[3:0];
				`MA_CR_HALT:
					strand_enable_o <= 4'b0000;
				default:
					;
			endcase
		end
	end

endmodule

/* hdl/writeback_latch.sv */
// Writeback register
// Hands the instruction and its result to the next stage,
// turning a flushed instruction into a NOP
`timescale 1ns/1ns
`include "mem_access_settings.svh"

module writeback_latch
(
	input	logic						clk,
	input	logic						arst_n_i,
	input	mem_access_pkg::ma_issue_t	issue_i,
	input	logic						flush_i,
	input	mem_access_pkg::line_t		result_i,
	input	mem_access_pkg::lane_idx_t	cache_lane_i,
	input	logic						access_i,
	output	mem_access_pkg::ma_wb_t		wb_o
);

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			wb_o.valid <= 1'b0;
			wb_o.has_writeback <= 1'b0;
			wb_o.was_access <= 1'b0;
		end
		else
		begin
			wb_o.valid <= issue_i.valid && !flush_i;
			wb_o.has_writeback <= issue_i.has_writeback && !flush_i;
			wb_o.instruction <= flush_i ? `MA_NOP : issue_i.instruction;
			wb_o.was_access <= access_i;
			wb_o.strand <= issue_i.strand;
			wb_o.pc <= issue_i.pc;
			wb_o.mask <= issue_i.mask;
			wb_o.result <= result_i;
			wb_o.reg_lane <= issue_i.reg_lane;
			wb_o.cache_lane <= cache_lane_i;
			wb_o.writeback_reg <= issue_i.writeback_reg;
			wb_o.writeback_is_vector <= issue_i.writeback_is_vector;
			wb_o.strided_offset <= issue_i.strided_offset;
		end
	end

endmodule

/* hdl/mem_access_stage.sv */
// Memory access stage
// Decodes memory ops, drives the data cache request combinationally
// and registers the writeback bundle
`timescale 1ns/1ns
`include "mem_access_settings.svh"

module mem_access_stage
#(
	parameter logic [29:0]	core_id_p = `MA_CORE_ID_DEFAULT
)
(
	input	logic						clk,
	input	logic						arst_n_i,
	input	mem_access_pkg::ma_issue_t	issue_i,
	input	logic						flush_i,
	output	mem_access_pkg::ma_dreq_t	dreq_o,
	output	mem_access_pkg::ma_wb_t		wb_o,
	output	logic [3:0]					strand_enable_o
);

	mem_access_pkg::ma_op_t		op;
	mem_access_pkg::addr_t		address;
	mem_access_pkg::lane_idx_t	cache_lane;
	mem_access_pkg::byte_en_t	byte_en;
	mem_access_pkg::line_t		data;
	mem_access_pkg::line_t		result_nxt;
	logic						access;
	logic						write;

	mem_op_decode i_decode (
		.instruction_i	(issue_i.instruction),
		.mask_i			(issue_i.mask),
		.reg_lane_i		(issue_i.reg_lane),
		.op_o			(op)
	);

	// Misalignment only reaches the bound checker
	mem_address_gen i_addr_gen (
		.op_i			(op),
		.issue_i		(issue_i),
		.flush_i		(flush_i),
		.address_o		(address),
		.cache_lane_o	(cache_lane),
		.access_o		(access),
		.write_o		(write),
		.unaligned_o	()
	);

	// Byte and half use the scalar pointer, so offset comes from result
	store_align i_store_align (
		.op_i			(op),
		.issue_i		(issue_i),
		.cache_lane_i	(cache_lane),
		.byte_offset_i	(issue_i.result[1:0]),
		.byte_en_o		(byte_en),
		.data_o			(data)
	);

	control_regs #(
		.core_id_p		(core_id_p)
	) i_ctrl_regs (
		.clk			(clk),
		.arst_n_i		(arst_n_i),
		.op_i			(op),
		.issue_i		(issue_i),
		.flush_i		(flush_i),
		.result_nxt_o	(result_nxt),
		.strand_enable_o(strand_enable_o)
	);

	writeback_latch i_wb_latch (
		.clk			(clk),
		.arst_n_i		(arst_n_i),
		.issue_i		(issue_i),
		.flush_i		(flush_i),
		.result_i		(result_nxt),
		.cache_lane_i	(cache_lane),
		.access_i		(access),
		.wb_o			(wb_o)
	);

	always_comb
	begin
		dreq_o.access = access;
		dreq_o.write = write;
		dreq_o.sync = op.kind == mem_access_pkg::MEM_SYNC;
		dreq_o.strand = issue_i.strand;
		dreq_o.address = address;
		dreq_o.cache_lane = cache_lane;
		dreq_o.byte_en = byte_en;
		dreq_o.data = data;
	end

endmodule

/* bench/mem_access_chk.sv */
// Memory access stage assertions
// Alignment, write gating and the strand enable reset value
`timescale 1ns/1ns

module mem_access_chk
(
	input	logic		clk,
	input	logic		arst_n_i,
	input	logic		access_i,
	input	logic		write_i,
	input	logic		lane_active_i,
	input	logic		unaligned_i,
	input	logic [3:0]	strand_enable_i
);

	int fail_count = 0;

	a_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
		access_i |-> !unaligned_i)
	else
	begin
		fail_count++;
		$error("Cache access issued to an unaligned address");
	end

	// A store on a masked-off lane writes nothing to the cache
	a_write: assert property (@(posedge clk) disable iff (!arst_n_i)
		write_i |-> access_i || !lane_active_i)
	else
	begin
		fail_count++;
		$error("Write raised without an access on an active lane");
	end

	a_reset: assert property (@(posedge clk) $rose(arst_n_i) |-> strand_enable_i == 4'b0001)
	else
	begin
		fail_count++;
		$error("Strand enable is not 1 right after reset");
	end

endmodule

/* bench/mem_access_monitor.sv */
// Memory access stage monitor
// Reference model of the cache request, control registers and
// writeback bundle, compared against the DUT on every falling edge
`timescale 1ns/1ns
`include "mem_access_settings.svh"

module mem_access_monitor
#(
	parameter logic [29:0]	core_id_p = `MA_CORE_ID_DEFAULT
)
(
	input	logic						clk,
	input	logic						arst_n_i,
	input	mem_access_pkg::ma_issue_t	issue_i,
	input	logic						flush_i,
	input	mem_access_pkg::ma_dreq_t	dreq_i,
	input	mem_access_pkg::ma_wb_t		wb_i,
	input	logic [3:0]					strand_enable_i
);

	int							errors = 0;
	int							checks = 0;
	int							seen = 0;		// Valid issues whose writeback was checked
	mem_access_pkg::word_t		scratch_m;
	logic [3:0]					strand_en_m;
	mem_access_pkg::ma_wb_t		wb_q[$];
	bit							src_valid_q[$];

	function automatic mem_access_pkg::word_t bswap(input mem_access_pkg::word_t w);
		mem_access_pkg::word_t s;
		for (int b = 0; b < 4; b++)
			s[8*b +: 8] = w[8*(3-b) +: 8];
		return s;
	endfunction

	function automatic mem_access_pkg::ma_dreq_t ref_dreq(input mem_access_pkg::ma_issue_t is,
		input logic fl);
		mem_access_pkg::ma_dreq_t	d;
		mem_access_pkg::addr_t		ptr;
		mem_access_pkg::word_t		rep;
		logic [3:0]					op;
		logic [1:0]					off;
		logic						is_mem, store, lane_on, go, sel;
		logic						byt, half, blk, strd, gath, ctrl;
		int							wi;
		op = is.instruction[`MA_OP_HI:`MA_OP_LO];
		is_mem = is.instruction[`MA_FMT_HI:`MA_FMT_LO] == `MA_FMT_MEM;
		store = !is.instruction[`MA_LS_BIT];
		byt = op inside {`MA_OP_B, `MA_OP_BX};
		half = op inside {`MA_OP_S, `MA_OP_SX};
		blk = op inside {`MA_OP_BLOCK, `MA_OP_BLOCK_M, `MA_OP_BLOCK_IM};
		strd = op inside {`MA_OP_STRIDED, `MA_OP_STRIDED_M, `MA_OP_STRIDED_IM};
		gath = op inside {`MA_OP_SCGATH, `MA_OP_SCGATH_M, `MA_OP_SCGATH_IM};
		ctrl = op == `MA_OP_CTRL;
		lane_on = is.mask[`MA_LANES - 1 - is.reg_lane];
		if (strd)
			ptr = is.base_addr + is.strided_offset;
		else if (gath)
			ptr = is.result[(`MA_LANES - 1 - is.reg_lane) * 32 +: 32];
		else
			ptr = is.result[31:0];
		off = is.result[1:0];
		go = is.valid && !fl && is_mem;
		d.access = go && (blk || (!ctrl && lane_on));
		d.write = go && store && !ctrl;
		d.sync = op == `MA_OP_SYNC;
		d.strand = is.strand;
		d.address = ptr & ~32'h3f;
		d.cache_lane = ptr[5:2];
		for (int p = 0; p < 64; p++)
		begin
			wi = p / 4;		// Byte p counts from the top of the line
			if (blk)
				sel = is.mask[`MA_LANES - 1 - wi];
			else
				sel = wi == d.cache_lane && (lane_on || !(strd || gath));
			if (byt)
				sel = sel && p % 4 == off;
			else if (half)
				sel = sel && (p % 4) / 2 == off[1];
			d.byte_en[63 - p] = sel;
		end
		rep = '0;
		if (byt)
			rep[31 - 8*off -: 8] = is.store_value[7:0];
		else if (half && off[1])
			rep[15:0] = {is.store_value[7:0], is.store_value[15:8]};
		else if (half)
			rep[31:16] = {is.store_value[7:0], is.store_value[15:8]};
		else if (strd || gath)
			rep = bswap(is.store_value[(`MA_LANES - 1 - is.reg_lane) * 32 +: 32]);
		else
			rep = bswap(is.store_value[31:0]);
		for (int w = 0; w < `MA_LANES; w++)
			d.data[w*32 +: 32] = blk ? bswap(is.store_value[w*32 +: 32]) : rep;
		return d;
	endfunction

	function automatic mem_access_pkg::line_t ref_result(input mem_access_pkg::ma_issue_t is);
		logic rd;
		rd = is.instruction[`MA_FMT_HI:`MA_FMT_LO] == `MA_FMT_MEM && is.instruction[`MA_LS_BIT]
			&& is.instruction[`MA_OP_HI:`MA_OP_LO] == `MA_OP_CTRL;
		if (!rd)
			return is.result;
		case (is.instruction[`MA_CR_HI:`MA_CR_LO])
			`MA_CR_STRAND_ID:	return mem_access_pkg::line_t'({core_id_p, is.strand});
			`MA_CR_SCRATCH:		return mem_access_pkg::line_t'(scratch_m);
			`MA_CR_STRAND_EN:	return mem_access_pkg::line_t'(strand_en_m);
			default:			return '0;
		endcase
	endfunction

	task automatic check(input string name, input logic [1023:0] got, input logic [1023:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch %s at %0t: got %0h, expected %0h", name, $time, got, exp);
		end
	endtask

	always @(negedge clk)
	begin
		mem_access_pkg::ma_dreq_t	exp_d;
		mem_access_pkg::ma_wb_t		exp_wb;
		if (!arst_n_i)
		begin
			check("wb_o.valid", wb_i.valid, 0);
			check("wb_o.has_writeback", wb_i.has_writeback, 0);
			check("wb_o.was_access", wb_i.was_access, 0);
			check("strand_enable_o", strand_enable_i, 4'b0001);
			scratch_m = '0;
			strand_en_m = 4'b0001;
			wb_q.delete();
			src_valid_q.delete();
		end
		else
		begin
			if (wb_q.size() != 0)
			begin
				exp_wb = wb_q.pop_front();
				check("wb_o.valid", wb_i.valid, exp_wb.valid);
				check("wb_o.has_writeback", wb_i.has_writeback, exp_wb.has_writeback);
				check("wb_o.instruction", wb_i.instruction, exp_wb.instruction);
				check("wb_o.was_access", wb_i.was_access, exp_wb.was_access);
				check("wb_o.result", wb_i.result, exp_wb.result);
				check("wb_o", wb_i, exp_wb);		// Pass-through fields
				if (src_valid_q.pop_front())
					seen++;
			end
			check("strand_enable_o", strand_enable_i, strand_en_m);
			exp_d = ref_dreq(issue_i, flush_i);
			check("dreq_o.access", dreq_i.access, exp_d.access);
			check("dreq_o.write", dreq_i.write, exp_d.write);
			check("dreq_o.sync", dreq_i.sync, exp_d.sync);
			check("dreq_o.strand", dreq_i.strand, exp_d.strand);
			check("dreq_o.address", dreq_i.address, exp_d.address);
			check("dreq_o.cache_lane", dreq_i.cache_lane, exp_d.cache_lane);
			check("dreq_o.byte_en", dreq_i.byte_en, exp_d.byte_en);
			check("dreq_o.data", dreq_i.data, exp_d.data);
			exp_wb.valid = issue_i.valid && !flush_i;
			exp_wb.instruction = flush_i ? `MA_NOP : issue_i.instruction;
			exp_wb.strand = issue_i.strand;
			exp_wb.pc = issue_i.pc;
			exp_wb.mask = issue_i.mask;
			exp_wb.result = ref_result(issue_i);
			exp_wb.reg_lane = issue_i.reg_lane;
			exp_wb.cache_lane = exp_d.cache_lane;
			exp_wb.has_writeback = issue_i.has_writeback && !flush_i;
			exp_wb.writeback_reg = issue_i.writeback_reg;
			exp_wb.writeback_is_vector = issue_i.writeback_is_vector;
			exp_wb.was_access = exp_d.access;
			exp_wb.strided_offset = issue_i.strided_offset;
			wb_q.push_back(exp_wb);
			src_valid_q.push_back(issue_i.valid);
			// Control writes land at the next rising edge
			if (issue_i.valid && !flush_i && issue_i.instruction[`MA_FMT_HI:`MA_FMT_LO] == `MA_FMT_MEM
				&& !issue_i.instruction[`MA_LS_BIT]
				&& issue_i.instruction[`MA_OP_HI:`MA_OP_LO] == `MA_OP_CTRL)
			begin
				case (issue_i.instruction[`MA_CR_HI:`MA_CR_LO])
					`MA_CR_SCRATCH:		scratch_m = issue_i.store_value[31:0];
					`MA_CR_STRAND_EN:	strand_en_m = issue_i.store_value[3:0];
					`MA_CR_HALT:		strand_en_m = 4'b0000;
					default:			;
				endcase
			end
		end
	end

endmodule

/* bench/mem_access_tb.sv */
// Memory access stage testbench
// Clock, reset, directed and random issues into the DUT
`timescale 1ns/1ns
`include "mem_access_settings.svh"

module mem_access_tb;

	localparam logic [29:0]	core_id = 30'h12a5_c3d;

	logic						clk = 1'b0;
	logic						arst_n;
	logic						flush;
	logic [3:0]					strand_enable;
	mem_access_pkg::ma_issue_t	issue;
	mem_access_pkg::ma_dreq_t	dreq;
	mem_access_pkg::ma_wb_t		wb;
	int							issued;
	int							errs_prev;

	mem_access_stage #(.core_id_p(core_id)) i_dut (
		.clk			(clk),
		.arst_n_i		(arst_n),
		.issue_i		(issue),
		.flush_i		(flush),
		.dreq_o			(dreq),
		.wb_o			(wb),
		.strand_enable_o(strand_enable)
	);

	mem_access_monitor #(.core_id_p(core_id)) i_mon (
		.clk			(clk),
		.arst_n_i		(arst_n),
		.issue_i		(issue),
		.flush_i		(flush),
		.dreq_i			(dreq),
		.wb_i			(wb),
		.strand_enable_i(strand_enable)
	);

	// Misalignment only exists inside the address generator
	bind mem_access_stage mem_access_chk i_chk (
		.clk			(clk),
		.arst_n_i		(arst_n_i),
		.access_i		(access),
		.write_i		(write),
		.lane_active_i	(op.lane_active),
		.unaligned_i	(i_addr_gen.unaligned_o),
		.strand_enable_i(strand_enable_o)
	);

	initial
	begin
		forever #4 clk = ~clk;
	end

	function automatic mem_access_pkg::word_t instr(input logic [3:0] op, input logic load,
		input mem_access_pkg::cr_idx_t cr);
		mem_access_pkg::word_t w;
		w = '0;
		w[`MA_FMT_HI:`MA_FMT_LO] = `MA_FMT_MEM;
		w[`MA_LS_BIT] = load;
		w[`MA_OP_HI:`MA_OP_LO] = op;
		w[`MA_CR_HI:`MA_CR_LO] = cr;
		return w;
	endfunction

	function automatic mem_access_pkg::ma_issue_t random_issue(input logic [3:0] op,
		input logic load);
		mem_access_pkg::ma_issue_t is;
		is.valid = 1'b1;
		is.instruction = instr(op, load, 5'($urandom));
		is.strand = 2'($urandom);
		is.pc = $urandom & ~32'h3;
		for (int i = 0; i < `MA_LANES; i++)
		begin
			is.store_value[i*32 +: 32] = $urandom;
			is.result[i*32 +: 32] = $urandom & ~32'h3;		// Word aligned pointers
		end
		is.mask = 16'($urandom);
		is.reg_lane = 4'($urandom);
		is.base_addr = $urandom & ~32'h3;
		is.strided_offset = $urandom & ~32'h3;
		is.has_writeback = 1'($urandom);
		is.writeback_reg = 7'($urandom);
		is.writeback_is_vector = 1'($urandom);
		if (op inside {`MA_OP_BLOCK, `MA_OP_BLOCK_M, `MA_OP_BLOCK_IM})
			is.result[5:0] = 6'd0;
		return is;
	endfunction

	function automatic mem_access_pkg::ma_issue_t ctrl_issue(input logic load,
		input mem_access_pkg::cr_idx_t cr, input mem_access_pkg::word_t value);
		mem_access_pkg::ma_issue_t is;
		is = random_issue(`MA_OP_CTRL, load);
		is.instruction = instr(`MA_OP_CTRL, load, cr);
		is.store_value[31:0] = value;
		return is;
	endfunction

	function automatic int total_errors();
		return i_mon.errors + i_dut.i_chk.fail_count;
	endfunction

	task automatic send(input mem_access_pkg::ma_issue_t is, input logic fl);
		@(posedge clk);
		issue <= is;
		flush <= fl;
		if (is.valid)
			issued++;
	endtask

	task automatic apply_reset();
		@(posedge clk);
		arst_n <= 1'b0;
		issue.valid <= 1'b0;
		flush <= 1'b0;
		repeat (8) @(posedge clk);
		arst_n <= 1'b1;
	endtask

	// Idle, then wait until every issue has had its writeback checked
	task automatic end_test(input string name);
		int n;
		int errs;
		@(posedge clk);
		issue.valid <= 1'b0;
		flush <= 1'b0;
		n = 0;
		while (i_mon.seen != issued && n < 20)
		begin
			@(posedge clk);
			n++;
		end
		if (i_mon.seen != issued)
		begin
			$display("Timeout in test %s: writeback never arrived for every issue", name);
			$display("Finished with errors");
			$finish;
		end
		else
		begin
			errs = total_errors();
			$display("Test %-8s done, %0d errors", name, errs - errs_prev);
			errs_prev = errs;
		end
	endtask

	initial
	begin
		mem_access_pkg::ma_issue_t	is;
		mem_access_pkg::word_t		v;
		int							errs;
		void'($urandom(32'h072b2b85));
		arst_n = 1'b0;
		flush = 1'b0;
		issue = '0;
		issued = 0;
		errs_prev = 0;
		repeat (8) @(posedge clk);
		arst_n <= 1'b1;

		for (int off = 0; off < 4; off++)
		begin
			is = random_issue(off[0] ? `MA_OP_BX : `MA_OP_B, 1'b0);
			is.mask = '1;
			is.result[1:0] = 2'(off);
			send(is, 1'b0);
			if (off % 2 == 0)
			begin
				is = random_issue(off == 0 ? `MA_OP_S : `MA_OP_SX, 1'b0);
				is.mask = '1;
				is.result[1:0] = 2'(off);
				send(is, 1'b0);
			end
		end
		is = random_issue(`MA_OP_L, 1'b0);
		is.mask = '1;
		send(is, 1'b0);
		send(random_issue(`MA_OP_B, 1'b1), 1'b0);
		send(random_issue(`MA_OP_S, 1'b1), 1'b0);
		send(random_issue(`MA_OP_L, 1'b1), 1'b0);
		send(random_issue(`MA_OP_SYNC, 1'b0), 1'b0);
		end_test("scalar");

		repeat (6)
			send(random_issue(`MA_OP_BLOCK + 4'($urandom_range(0, 2)), 1'b0), 1'b0);
		end_test("block");

		for (int lane = 0; lane < `MA_LANES; lane++)
		begin
			is = random_issue(`MA_OP_STRIDED + 4'(lane % 3), 1'b0);
			is.reg_lane = 4'(lane);
			is.mask[`MA_LANES - 1 - lane] = lane % 2 == 0;
			send(is, 1'b0);
			is = random_issue(`MA_OP_SCGATH + 4'(lane % 3), 1'b0);
			is.reg_lane = 4'(lane);
			is.mask[`MA_LANES - 1 - lane] = lane % 2 == 1;
			send(is, 1'b0);
		end
		end_test("strided");

		v = $urandom;
		send(ctrl_issue(1'b0, `MA_CR_SCRATCH, v), 1'b0);
		send(ctrl_issue(1'b1, `MA_CR_SCRATCH, 32'd0), 1'b0);
		send(ctrl_issue(1'b0, `MA_CR_STRAND_EN, 32'h0000_000b), 1'b0);
		send(ctrl_issue(1'b1, `MA_CR_STRAND_EN, 32'd0), 1'b0);
		send(ctrl_issue(1'b1, `MA_CR_STRAND_ID, 32'd0), 1'b0);
		send(ctrl_issue(1'b0, `MA_CR_HALT, 32'd0), 1'b0);
		send(ctrl_issue(1'b1, `MA_CR_STRAND_EN, 32'd0), 1'b0);
		end_test("control");

		is = random_issue(`MA_OP_L, 1'b0);
		is.mask = '1;
		send(is, 1'b1);
		send(ctrl_issue(1'b0, `MA_CR_SCRATCH, ~v), 1'b1);		// Dropped write
		send(ctrl_issue(1'b1, `MA_CR_SCRATCH, 32'd0), 1'b0);
		end_test("flush");
		apply_reset();
		end_test("reset");

		repeat (60)
		begin
			is = random_issue(4'($urandom), 1'($urandom));
			if ($urandom_range(0, 3) == 0)
				is.instruction[`MA_FMT_HI:`MA_FMT_LO] = 2'($urandom);
			send(is, $urandom_range(0, 7) == 0);
		end
		end_test("random");

		errs = total_errors();
		$display("Checks %0d, mismatches %0d, assertion failures %0d",
			i_mon.checks, i_mon.errors, i_dut.i_chk.fail_count);
		if (errs == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

/* compile.f */
+incdir+common
common/mem_access_pkg.sv
hdl/mem_op_decode.sv
hdl/mem_address_gen.sv
store_align/store_align.sv
hdl/control_regs.sv
hdl/writeback_latch.sv
hdl/mem_access_stage.sv
bench/mem_access_chk.sv
bench/mem_access_monitor.sv
bench/mem_access_tb.sv

/* Bender.yml */
package:
  name: mem_access_stage

export_include_dirs:
  - common

sources:
  - common/mem_access_pkg.sv
  - hdl/mem_op_decode.sv
  - hdl/mem_address_gen.sv
  - store_align/store_align.sv
  - hdl/control_regs.sv
  - hdl/writeback_latch.sv
  - hdl/mem_access_stage.sv
  - target: test
    files:
      - bench/mem_access_chk.sv
      - bench/mem_access_monitor.sv
      - bench/mem_access_tb.sv
